//--- Bender.yml
package:
  name: rv64i_core

export_include_dirs:
  - include

sources:
  - logic/rv_isa_pkg.sv
  - logic/core_ctrl_pkg.sv
  - logic/inst_decoder.sv
  - logic/alu_exec.sv
  - logic/wb_select.sv
  - logic/reg_file.sv
  - logic/data_mem.sv
  - logic/rv_core.sv
  - target: test
    files:
      - test/core_tb.sv

//--- filelist.f
+incdir+include
logic/rv_isa_pkg.sv
logic/core_ctrl_pkg.sv
logic/inst_decoder.sv
logic/alu_exec.sv
logic/wb_select.sv
logic/reg_file.sv
logic/data_mem.sv
logic/rv_core.sv
test/core_tb.sv

//--- include/core_defs.svh
// widths are fixed for rv64i; modules are not meant to be rebuilt with other values
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// data and address width
`define XLEN 64

// instruction word width
`define ILEN 32

// register index width and number of architectural registers
`define REG_IDX_W 5
`define NUM_REGS 32

// data memory depth in doublewords, must be a power of two
`define DMEM_DEPTH 256

`endif

//--- logic/alu_exec.sv
// add, sub and signed slt only; jump targets are not checked for alignment
`include "core_defs.svh"
`default_nettype none

module alu_exec (
  input  wire logic [`XLEN-1:0]       pc,
  input  wire logic [`XLEN-1:0]       rs1_data,
  input  wire logic [`XLEN-1:0]       rs2_data,
  input  wire logic [`XLEN-1:0]       imm,
  input  wire logic                   need_imm,
  input  wire rv_isa_pkg::alu_op_e    alu_op,
  input  wire logic                   is_auipc,
  input  wire logic                   is_jal,
  input  wire logic                   is_jalr,
  output logic [`XLEN-1:0]            alu_result,
  output logic [`XLEN-1:0]            next_pc
);

  logic [`XLEN-1:0] op_a;
  logic [`XLEN-1:0] op_b;
  logic [`XLEN-1:0] jalr_sum;

  // auipc adds to pc, everything else to rs1
  assign op_a = is_auipc ? pc : rs1_data;
  assign op_b = need_imm ? imm : rs2_data;

  // also the effective address for ld and sd
  always_comb begin
    case (alu_op)
      rv_isa_pkg::ALU_SUB: alu_result = op_a - op_b;
      rv_isa_pkg::ALU_SLT: alu_result = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      default:             alu_result = op_a + op_b;
    endcase
  end

  assign jalr_sum = rs1_data + imm;

  // next pc
  always_comb begin
    if (is_jal) begin
      next_pc = pc + imm;
    end else if (is_jalr) begin
      // jalr drops bit 0 of the target
      next_pc = {jalr_sum[`XLEN-1:1], 1'b0};
    end else begin
      next_pc = pc + `XLEN'd4;
    end
  end

endmodule

`default_nettype wire

//--- logic/core_ctrl_pkg.sv
// core-internal control types; halt is left only through reset
`default_nettype none

package core_ctrl_pkg;

  // run state of the single-cycle core
  typedef enum logic {
    RUN  = 1'b0,
    HALT = 1'b1
  } run_state_e;

  // source of the register write-back value
  typedef enum logic [1:0] {
    WB_ALU  = 2'd0,
    WB_LOAD = 2'd1,
    // pc + 4 for jal and jalr
    WB_LINK = 2'd2
  } wb_src_e;

endpackage

`default_nettype wire

//--- logic/data_mem.sv
// address wraps modulo the depth and bits 2:0 are ignored; contents are undefined until stored
`include "core_defs.svh"
`default_nettype none

module data_mem (
  input  wire logic               clk,
  input  wire logic [`XLEN-1:0]   addr,
  input  wire logic               wen,
  input  wire logic [`XLEN/8-1:0] wmask,
  input  wire logic [`XLEN-1:0]   wdata,
  output logic [`XLEN-1:0]        rdata
);

  localparam int IDX_W = $clog2(`DMEM_DEPTH);

  logic [`XLEN-1:0] mem [`DMEM_DEPTH];
  logic [IDX_W-1:0] idx;

  // doubleword index
  assign idx = addr[IDX_W+2:3];

  // byte lanes written independently
  always_ff @(posedge clk) begin
    if (wen) begin
      for (int b = 0; b < `XLEN/8; b++) begin
        if (wmask[b]) begin
          mem[idx][8*b +: 8] <= wdata[8*b +: 8];
        end
      end
    end
  end

  assign rdata = mem[idx];

endmodule

`default_nettype wire

//--- logic/inst_decoder.sv
// decodes addi slti add sub auipc jal jalr ld sd ebreak; the zero word is a nop, all else flagged
`include "core_defs.svh"
`default_nettype none

module inst_decoder (
  input  wire logic [`ILEN-1:0]      inst,
  output logic [`REG_IDX_W-1:0]      rd,
  output logic [`REG_IDX_W-1:0]      rs1,
  output logic [`REG_IDX_W-1:0]      rs2,
  output logic [`XLEN-1:0]           imm,
  output logic                       need_imm,
  output rv_isa_pkg::alu_op_e        alu_op,
  output core_ctrl_pkg::wb_src_e     wb_src,
  output logic                       is_auipc,
  output logic                       is_jal,
  output logic                       is_jalr,
  output logic                       is_ebreak,
  output logic                       reg_wen,
  output logic                       mem_wen,
  output logic [7:0]                 wmask,
  output logic                       inst_not_ipl
);

  rv_isa_pkg::opcode_e opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [11:0] funct12;
  logic        nop;
  logic        addi, slti, add, sub, ld, sd;

  // instruction fields
  assign opcode  = rv_isa_pkg::opcode_e'(inst[6:0]);
  assign funct3  = inst[14:12];
  assign funct7  = inst[31:25];
  assign funct12 = inst[31:20];
  assign rd      = inst[11:7];
  assign rs1     = inst[19:15];
  assign rs2     = inst[24:20];

  // all-zero word retires as a no-op
  assign nop = (inst == '0);

  // one-hot instruction matches
  assign addi      = (opcode == rv_isa_pkg::OP_IMM) && (funct3 == 3'b000);
  assign slti      = (opcode == rv_isa_pkg::OP_IMM) && (funct3 == 3'b010);
  assign add       = (opcode == rv_isa_pkg::OP) && (funct3 == 3'b000) && (funct7 == 7'b0000000);
  assign sub       = (opcode == rv_isa_pkg::OP) && (funct3 == 3'b000) && (funct7 == 7'b0100000);
  assign is_auipc  = (opcode == rv_isa_pkg::AUIPC);
  assign is_jal    = (opcode == rv_isa_pkg::JAL);
  assign is_jalr   = (opcode == rv_isa_pkg::JALR) && (funct3 == 3'b000);
  assign ld        = (opcode == rv_isa_pkg::LOAD) && (funct3 == 3'b011);
  assign sd        = (opcode == rv_isa_pkg::STORE) && (funct3 == 3'b011);
  assign is_ebreak = (opcode == rv_isa_pkg::SYSTEM) && (funct3 == 3'b000) &&
                     (funct12 == 12'h001);

  // immediate by format, sign bit is always inst[31]
  always_comb begin
    if (is_auipc) begin
      imm = {{(`XLEN-32){inst[31]}}, inst[31:12], 12'b0};
    end else if (is_jal) begin
      imm = {{(`XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    end else if (sd) begin
      imm = {{(`XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
    end else begin
      // i-type, harmless for r-type since need_imm is low
      imm = {{(`XLEN-12){inst[31]}}, inst[31:20]};
    end
  end

  // operand b comes from the immediate
  assign need_imm = addi | slti | is_auipc | is_jalr | ld | sd;

  always_comb begin
    if (sub) begin
      alu_op = rv_isa_pkg::ALU_SUB;
    end else if (slti) begin
      alu_op = rv_isa_pkg::ALU_SLT;
    end else begin
      alu_op = rv_isa_pkg::ALU_ADD;
    end
  end

  always_comb begin
    if (ld) begin
      wb_src = core_ctrl_pkg::WB_LOAD;
    end else if (is_jal || is_jalr) begin
      wb_src = core_ctrl_pkg::WB_LINK;
    end else begin
      wb_src = core_ctrl_pkg::WB_ALU;
    end
  end

  // only instructions that really write rd
  assign reg_wen = addi | slti | add | sub | is_auipc | is_jal | is_jalr | ld;
  assign mem_wen = sd;
  // full doubleword store
  assign wmask   = sd ? 8'hff : 8'h00;

  assign inst_not_ipl = ~(addi | slti | add | sub | is_auipc | is_jal | is_jalr |
                          ld | sd | is_ebreak | nop);

endmodule

`default_nettype wire

//--- logic/reg_file.sv
// asynchronous reads; a write is visible to reads only after the clock edge
`include "core_defs.svh"
`default_nettype none

module reg_file (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic [`REG_IDX_W-1:0] rs1,
  input  wire logic [`REG_IDX_W-1:0] rs2,
  input  wire logic [`REG_IDX_W-1:0] rd,
  input  wire logic                  wen,
  input  wire logic [`XLEN-1:0]      wdata,
  output logic [`XLEN-1:0]           rs1_data,
  output logic [`XLEN-1:0]           rs2_data
);

  logic [`XLEN-1:0] regs [`NUM_REGS];

  // x0 is never written
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && (rd != '0)) begin
      regs[rd] <= wdata;
    end
  end

  // x0 reads as zero
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

//--- logic/rv_core.sv
// single cycle core, fetch is combinational from outside; halt on ebreak or bad word until reset
`include "core_defs.svh"
`default_nettype none

module rv_core (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic [`ILEN-1:0]      inst,
  output logic [`XLEN-1:0]           pc,
  output logic                       halted,
  output logic                       illegal,
  output logic                       retire_valid,
  output logic [`XLEN-1:0]           retire_pc,
  output logic [`ILEN-1:0]           retire_inst,
  output logic                       retire_wen,
  output logic [`REG_IDX_W-1:0]      retire_rd,
  output logic [`XLEN-1:0]           retire_wdata
);

  core_ctrl_pkg::run_state_e state;
  logic                      running;

  // decoder outputs
  logic [`REG_IDX_W-1:0]  rd, rs1, rs2;
  logic [`XLEN-1:0]       imm;
  logic                   need_imm;
  rv_isa_pkg::alu_op_e    alu_op;
  core_ctrl_pkg::wb_src_e wb_src;
  logic                   is_auipc, is_jal, is_jalr, is_ebreak;
  logic                   reg_wen, mem_wen, inst_not_ipl;
  logic [7:0]             wmask;

  // datapath
  logic [`XLEN-1:0] rs1_data, rs2_data;
  logic [`XLEN-1:0] alu_result, next_pc;
  logic [`XLEN-1:0] load_data, wb_data;
  logic             rf_wen, dm_wen;

  // one instruction retires per cycle while running
  assign running = rst_n && (state == core_ctrl_pkg::RUN);

  // write gating, x0 writes do not count as writes
  assign rf_wen = running && reg_wen && !inst_not_ipl && (rd != '0);
  assign dm_wen = running && mem_wen && !inst_not_ipl;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc      <= '0;
      state   <= core_ctrl_pkg::RUN;
      illegal <= 1'b0;
    end else if (state == core_ctrl_pkg::RUN) begin
      pc <= next_pc;
      // ebreak and unknown words stop after they commit
      if (is_ebreak || inst_not_ipl) begin
        state <= core_ctrl_pkg::HALT;
      end
      if (inst_not_ipl) begin
        illegal <= 1'b1;
      end
    end
  end

  assign halted = (state == core_ctrl_pkg::HALT);

  inst_decoder u_dec (
    .inst(inst), .rd(rd), .rs1(rs1), .rs2(rs2), .imm(imm), .need_imm(need_imm),
    .alu_op(alu_op), .wb_src(wb_src), .is_auipc(is_auipc), .is_jal(is_jal),
    .is_jalr(is_jalr), .is_ebreak(is_ebreak), .reg_wen(reg_wen), .mem_wen(mem_wen),
    .wmask(wmask), .inst_not_ipl(inst_not_ipl)
  );

  alu_exec u_exec (
    .pc(pc), .rs1_data(rs1_data), .rs2_data(rs2_data), .imm(imm), .need_imm(need_imm),
    .alu_op(alu_op), .is_auipc(is_auipc), .is_jal(is_jal), .is_jalr(is_jalr),
    .alu_result(alu_result), .next_pc(next_pc)
  );

  wb_select u_wb (
    .wb_src(wb_src), .alu_result(alu_result), .load_data(load_data), .pc(pc),
    .wb_data(wb_data)
  );

  reg_file u_rf (
    .clk(clk), .rst_n(rst_n), .rs1(rs1), .rs2(rs2), .rd(rd), .wen(rf_wen),
    .wdata(wb_data), .rs1_data(rs1_data), .rs2_data(rs2_data)
  );

  // store data is rs2, address is the alu sum
  data_mem u_dmem (
    .clk(clk), .addr(alu_result), .wen(dm_wen), .wmask(wmask), .wdata(rs2_data),
    .rdata(load_data)
  );

  // commit trace of the instruction retiring this cycle
  assign retire_valid = running;
  assign retire_pc    = pc;
  assign retire_inst  = inst;
  assign retire_wen   = rf_wen;
  assign retire_rd    = rd;
  assign retire_wdata = wb_data;

endmodule

`default_nettype wire

//--- logic/rv_isa_pkg.sv
// encodings for the supported rv64i subset only; other opcodes are not listed
`default_nettype none

package rv_isa_pkg;

  // major opcode field, inst[6:0]
  typedef enum logic [6:0] {
    // register-immediate arithmetic
    OP_IMM = 7'b0010011,
    // register-register arithmetic
    OP     = 7'b0110011,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    // ebreak lives here
    SYSTEM = 7'b1110011
  } opcode_e;

  // alu function
  typedef enum logic [1:0] {
    // also used for addresses and auipc
    ALU_ADD = 2'd0,
    ALU_SUB = 2'd1,
    // signed less-than, result is 0 or 1
    ALU_SLT = 2'd2
  } alu_op_e;

endpackage

`default_nettype wire

//--- logic/wb_select.sv
// the link value is always pc + 4; no compressed instructions
`include "core_defs.svh"
`default_nettype none

module wb_select (
  input  wire core_ctrl_pkg::wb_src_e wb_src,
  input  wire logic [`XLEN-1:0]       alu_result,
  input  wire logic [`XLEN-1:0]       load_data,
  input  wire logic [`XLEN-1:0]       pc,
  output logic [`XLEN-1:0]            wb_data
);

  logic [`XLEN-1:0] link_addr;

  // return address for jal and jalr
  assign link_addr = pc + `XLEN'd4;

  always_comb begin
    case (wb_src)
      core_ctrl_pkg::WB_LOAD: wb_data = load_data;
      core_ctrl_pkg::WB_LINK: wb_data = link_addr;
      default:                wb_data = alu_result;
    endcase
  end

endmodule

`default_nettype wire

//--- test/core_tb.sv
// needs the include folder on the search path; random programs keep x1 as the store base
`include "core_defs.svh"
`default_nettype none

module core_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [6:0] OPC_IMM   = 7'b0010011;
  localparam logic [6:0] OPC_OP    = 7'b0110011;
  localparam logic [6:0] OPC_AUIPC = 7'b0010111;
  localparam logic [6:0] OPC_JAL   = 7'b1101111;
  localparam logic [6:0] OPC_JALR  = 7'b1100111;
  localparam logic [6:0] OPC_LOAD  = 7'b0000011;
  localparam logic [6:0] OPC_STORE = 7'b0100011;
  localparam logic [31:0] EBREAK   = 32'h00100073;

  typedef struct packed {
    logic [`XLEN-1:0]      pc;
    logic                  wen;
    logic [`REG_IDX_W-1:0] rd;
    logic [`XLEN-1:0]      wdata;
  } commit_t;

  logic clk;
  logic rst_n = 1'b0;
  logic [`ILEN-1:0] inst;
  logic [`XLEN-1:0] pc, retire_pc, retire_wdata;
  logic [`ILEN-1:0] retire_inst;
  logic [`REG_IDX_W-1:0] retire_rd;
  logic halted, illegal, retire_valid, retire_wen;

  // instruction memory of 1024 words
  logic [31:0] imem [1024];
  int prog_len;
  // reference model state
  logic [`XLEN-1:0] ref_x [`NUM_REGS];
  logic [`XLEN-1:0] ref_mem [`DMEM_DEPTH];
  logic [`XLEN-1:0] ref_pc;
  logic ref_halted, ref_illegal;
  logic [31:0] rng_state = 32'h6300ca0d;
  string test_name = "reset";
  int errors = 0;
  int wd_count = 0;
  int wd_limit = 0;
  logic wd_armed = 1'b0;

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // fetch answers pc in the same cycle and reads zero in reset
  assign inst = rst_n ? imem[pc[11:2]] : 32'h0;

  rv_core dut0 (
    .clk(clk), .rst_n(rst_n), .inst(inst), .pc(pc), .halted(halted), .illegal(illegal),
    .retire_valid(retire_valid), .retire_pc(retire_pc), .retire_inst(retire_inst),
    .retire_wen(retire_wen), .retire_rd(retire_rd), .retire_wdata(retire_wdata)
  );

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // instruction encoders by format
  function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                        logic [4:0] rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [4:0] rd);
    return {f7, rs2, rs1, 3'b000, rd, OPC_OP};
  endfunction

  function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], OPC_STORE};
  endfunction

  function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
  endfunction

  // steps the isa model by one word and returns what should commit
  function automatic commit_t ref_step(logic [31:0] w);
    commit_t c;
    logic [`XLEN-1:0] a, b, immi, imms, res, npc;
    logic [4:0] rd;
    logic wr;
    rd   = w[11:7];
    a    = ref_x[w[19:15]];
    b    = ref_x[w[24:20]];
    immi = {{52{w[31]}}, w[31:20]};
    imms = {{52{w[31]}}, w[31:25], w[11:7]};
    npc  = ref_pc + 64'd4;
    res  = '0;
    wr   = 1'b0;
    if (w == 32'h0) begin
      // no-op
    end else if (w[6:0] == OPC_IMM && w[14:12] == 3'b000) begin
      wr = 1'b1;
      res = a + immi;
    end else if (w[6:0] == OPC_IMM && w[14:12] == 3'b010) begin
      wr = 1'b1;
      res = ($signed(a) < $signed(immi)) ? 64'd1 : 64'd0;
    end else if (w[6:0] == OPC_OP && w[14:12] == 3'b000 && w[31:25] == 7'h00) begin
      wr = 1'b1;
      res = a + b;
    end else if (w[6:0] == OPC_OP && w[14:12] == 3'b000 && w[31:25] == 7'h20) begin
      wr = 1'b1;
      res = a - b;
    end else if (w[6:0] == OPC_AUIPC) begin
      wr = 1'b1;
      res = ref_pc + {{32{w[31]}}, w[31:12], 12'b0};
    end else if (w[6:0] == OPC_JAL) begin
      wr = 1'b1;
      res = ref_pc + 64'd4;
      npc = ref_pc + {{44{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    end else if (w[6:0] == OPC_JALR && w[14:12] == 3'b000) begin
      wr = 1'b1;
      res = ref_pc + 64'd4;
      npc = (a + immi) & ~64'd1;
    end else if (w[6:0] == OPC_LOAD && w[14:12] == 3'b011) begin
      wr = 1'b1;
      res = ref_mem[(a + immi) >> 3 & (`DMEM_DEPTH - 1)];
    end else if (w[6:0] == OPC_STORE && w[14:12] == 3'b011) begin
      ref_mem[(a + imms) >> 3 & (`DMEM_DEPTH - 1)] = b;
    end else if (w == EBREAK) begin
      ref_halted = 1'b1;
    end else begin
      ref_halted = 1'b1;
      ref_illegal = 1'b1;
    end
    c.pc = ref_pc;
    c.wen = wr && (rd != 5'd0);
    c.rd = rd;
    c.wdata = res;
    if (c.wen) begin
      ref_x[rd] = res;
    end
    ref_pc = npc;
    return c;
  endfunction

  task automatic mismatch(string field, logic [`XLEN-1:0] exp, logic [`XLEN-1:0] act);
    errors++;
    $display("[FAIL] %s %s: expected %h, actual %h", test_name, field, exp, act);
  endtask

  // compare every commit against the model at mid-cycle where the trace is stable
  always @(negedge clk) begin : compare_commits
    commit_t exp_c;
    logic [31:0] exp_w;
    if (rst_n && retire_valid) begin
      if (ref_halted) begin
        errors++;
        $display("%s: a commit appeared after the core should have halted", test_name);
      end else begin
        // word the model expects at its own pc
        exp_w = imem[ref_pc[11:2]];
        exp_c = ref_step(exp_w);
        if (retire_pc !== exp_c.pc) mismatch("pc", exp_c.pc, retire_pc);
        if (retire_inst !== exp_w) mismatch("inst", exp_w, retire_inst);
        if (retire_wen !== exp_c.wen) mismatch("wen", exp_c.wen, retire_wen);
        if (exp_c.wen && retire_rd !== exp_c.rd) mismatch("rd", exp_c.rd, retire_rd);
        if (exp_c.wen && retire_wdata !== exp_c.wdata) begin
          mismatch("wdata", exp_c.wdata, retire_wdata);
        end
      end
    end
  end

  // watchdog limit is set per program from its length
  always @(posedge clk) begin
    if (wd_armed) begin
      wd_count = wd_count + 1;
      if (wd_count > wd_limit) begin
        $display("%s: the core never halted within %0d cycles", test_name, wd_limit);
        $display("errors: %0d", errors);
        $display("*** TEST FAILED ***");
        $finish;
      end
    end
  end

  task automatic put(logic [31:0] w);
    imem[prog_len] = w;
    prog_len++;
  endtask

  // hold reset for 8 edges and check outputs before release
  task automatic do_reset();
    @(posedge clk);
    rst_n <= 1'b0;
    repeat (7) @(posedge clk);
    @(negedge clk);
    if (halted !== 1'b0) mismatch("halted in reset", 0, halted);
    if (illegal !== 1'b0) mismatch("illegal in reset", 0, illegal);
    if (retire_valid !== 1'b0) mismatch("retire_valid in reset", 0, retire_valid);
    for (int i = 0; i < `NUM_REGS; i++) begin
      ref_x[i] = '0;
    end
    ref_pc = '0;
    ref_halted = 1'b0;
    ref_illegal = 1'b0;
    @(posedge clk);
    rst_n <= 1'b1;
  endtask

  task automatic run_program(string name);
    test_name = name;
    wd_count = 0;
    wd_limit = 20 * prog_len + 10;
    wd_armed = 1'b1;
    do_reset();
    while (halted !== 1'b1) @(negedge clk);
    // a few idle cycles to catch stray commits
    repeat (4) @(negedge clk);
    wd_armed = 1'b0;
    if (!ref_halted) begin
      errors++;
      $display("%s: the core halted before the reference model did", name);
    end
    if (halted !== 1'b1) mismatch("halted", 1, halted);
    if (illegal !== ref_illegal) mismatch("illegal", ref_illegal, illegal);
    // pc stays on the word after the one that halted
    if (pc !== ref_pc) mismatch("pc after halt", ref_pc, pc);
  endtask

  task automatic gen_random_program();
    logic [31:0] r;
    logic [15:0] stored;
    logic [4:0] rd;
    int k;
    int first_k;
    stored = '0;
    first_k = 0;
    prog_len = 0;
    // x1 holds the store base and is never overwritten
    put(enc_i(12'd256, 5'd0, 3'b000, 5'd1, OPC_IMM));
    for (int n = 1; n < 199; n++) begin
      r = next_rand();
      rd = (r[4:0] == 5'd1) ? 5'd2 : r[4:0];
      k = next_rand() % 16;
      case (r[31:29])
        3'd0: put(enc_i(r[26:15], r[9:5], 3'b000, rd, OPC_IMM));
        3'd1: put(enc_i(r[26:15], r[9:5], 3'b010, rd, OPC_IMM));
        3'd2: put(enc_r(7'h00, r[14:10], r[9:5], rd));
        3'd3: put(enc_r(7'h20, r[14:10], r[9:5], rd));
        3'd4: put({r[28:9], rd, OPC_AUIPC});
        3'd7: begin
          if (stored == '0) begin
            stored[k] = 1'b1;
            first_k = k;
            put(enc_s(12'(k * 8), r[14:10], 5'd1));
          end else begin
            // only load doublewords this program already stored
            if (!stored[k]) k = first_k;
            put(enc_i(12'(k * 8), 5'd1, 3'b011, rd, OPC_LOAD));
          end
        end
        default: begin
          if (stored == '0) first_k = k;
          stored[k] = 1'b1;
          put(enc_s(12'(k * 8), r[14:10], 5'd1));
        end
      endcase
    end
    put(EBREAK);
  endtask

  initial begin
    // arithmetic and x0 writes
    prog_len = 0;
    put(enc_i(12'd5, 5'd0, 3'b000, 5'd2, OPC_IMM));
    put(enc_i(12'hffd, 5'd0, 3'b000, 5'd3, OPC_IMM));
    put(enc_i(12'd1, 5'd3, 3'b010, 5'd4, OPC_IMM));
    put(enc_i(12'hfff, 5'd2, 3'b010, 5'd5, OPC_IMM));
    put(enc_r(7'h00, 5'd3, 5'd2, 5'd6));
    put(enc_r(7'h20, 5'd2, 5'd3, 5'd7));
    put({20'h12345, 5'd8, OPC_AUIPC});
    put(enc_i(12'd7, 5'd2, 3'b000, 5'd0, OPC_IMM));
    put(enc_r(7'h00, 5'd2, 5'd2, 5'd0));
    put(enc_r(7'h20, 5'd2, 5'd0, 5'd9));
    put(EBREAK);
    run_program("arith");

    // stores then loads to the same and to different doublewords
    prog_len = 0;
    put(enc_i(12'd512, 5'd0, 3'b000, 5'd1, OPC_IMM));
    put(enc_i(12'hfb3, 5'd0, 3'b000, 5'd2, OPC_IMM));
    put(enc_i(12'd1234, 5'd0, 3'b000, 5'd3, OPC_IMM));
    put(enc_s(12'd0, 5'd2, 5'd1));
    put(enc_s(12'd8, 5'd3, 5'd1));
    put(enc_i(12'd0, 5'd1, 3'b011, 5'd4, OPC_LOAD));
    put(enc_i(12'd8, 5'd1, 3'b011, 5'd5, OPC_LOAD));
    put(enc_s(12'd0, 5'd3, 5'd1));
    put(enc_i(12'd0, 5'd1, 3'b011, 5'd6, OPC_LOAD));
    put(EBREAK);
    run_program("memory");

    // jal over two words, jalr with an odd offset, jal with rd x0
    prog_len = 0;
    put(enc_i(12'd24, 5'd0, 3'b000, 5'd2, OPC_IMM));
    put(enc_j(21'd12, 5'd1));
    put(enc_i(12'd1, 5'd0, 3'b000, 5'd3, OPC_IMM));
    put(EBREAK);
    put(enc_i(12'd1, 5'd2, 3'b000, 5'd5, OPC_JALR));
    put(enc_i(12'd9, 5'd0, 3'b000, 5'd4, OPC_IMM));
    put(enc_j(21'd8, 5'd0));
    put(EBREAK);
    put(enc_i(12'd3, 5'd0, 3'b000, 5'd6, OPC_IMM));
    put(EBREAK);
    run_program("jumps");

    for (int p = 0; p < 3; p++) begin
      gen_random_program();
      run_program($sformatf("random%0d", p));
    end

    // zero word is a nop and beq is not implemented
    prog_len = 0;
    put(enc_i(12'd1, 5'd0, 3'b000, 5'd2, OPC_IMM));
    put(32'h00000000);
    put(32'h00000463);
    put(enc_i(12'd2, 5'd0, 3'b000, 5'd3, OPC_IMM));
    run_program("unimpl");

    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire
